// ==== motor3.f ====
+incdir+.
motor3Pkg.sv
motor3WbRegs.sv
motor3StepTimer.sv
motor3Sequencer.sv
motor3PhaseMap.sv
motor3Top.sv
motor3Tb.sv

// ==== motor3PhaseMap.sv ====
`default_nettype none

`include "motor3_config.svh"

module motor3PhaseMap (
    input  logic [`STEP_W-1:0] stepA,
    output logic [`STEP_W-1:0] stepB,
    output logic [`STEP_W-1:0] stepC,
    output logic [2:0]         phaseHigh
);

    localparam logic [`STEP_W-1:0] NoStep = {`STEP_W{1'b1}};

    // Offset a step, wrapped into 1..12.
    function automatic logic [`STEP_W-1:0] offsetStep(
        input logic [`STEP_W-1:0] step,
        input logic [`STEP_W:0]   offset
    );
        logic [`STEP_W:0] sum;
        sum = {1'b0, step} + offset;
        if (step < 1 || step > 12) begin
            return NoStep;
        end
        if (sum > 12) begin
            sum = sum - 5'd12;
        end
        return sum[`STEP_W-1:0];
    endfunction

    // First half of the electrical cycle drives high.
    function automatic logic isHigh(input logic [`STEP_W-1:0] step);
        return (step >= 1 && step <= 6);
    endfunction

    // ========================================
    // B lags A by 4 steps, C by 8 steps.
    // ========================================

    always_comb begin
        stepB = offsetStep(stepA, 5'd8);
        stepC = offsetStep(stepA, 5'd4);
    end

    always_comb begin
        phaseHigh[0] = isHigh(stepA);
        phaseHigh[1] = isHigh(stepB);
        phaseHigh[2] = isHigh(stepC);
    end

endmodule

`default_nettype wire

// ==== motor3Pkg.sv ====
`default_nettype none

// ========================================
// Shared types for the step generator.
// ========================================

package motor3Pkg;

    // Sequencer states.
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        LOAD = 2'd1,
        RUN  = 2'd2
    } seqState_t;

    // Opcodes in REG_CTRL bits 2:0.
    typedef enum logic [2:0] {
        CMD_NONE   = 3'd0,
        CMD_START  = 3'd1,
        CMD_STOP   = 3'd2,
        CMD_FASTER = 3'd3,
        CMD_SLOWER = 3'd4
    } motorCmd_t;

    // Word addresses on the bus.
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,
        REG_RELOAD = 2'd1,
        REG_STEP   = 2'd2,
        REG_ROUND  = 2'd3
    } regAddr_t;

endpackage

`default_nettype wire

// ==== motor3Sequencer.sv ====
`default_nettype none

`include "motor3_config.svh"

module motor3Sequencer (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   startPulse,
    input  logic                   stopPulse,
    input  logic                   stepLast,
    output motor3Pkg::seqState_t   state,
    output logic                   timerLoad,
    output logic                   timerRun,
    output logic [`STEP_W-1:0]     stepA,
    output logic [`ROUND_W-1:0]    roundCount
);
    import motor3Pkg::*;

    localparam logic [`STEP_W-1:0] FirstStep = `STEP_W'd1;
    localparam logic [`STEP_W-1:0] LastStep  = `STEP_W'd12;

    logic roundDone;

    assign timerLoad = (state == LOAD);
    assign timerRun  = (state == RUN);
    assign roundDone = timerRun && stepLast && (stepA == LastStep);

    // ========================================
    // State machine and phase A step.
    // ========================================

    // Stop wins over start. Start in any state restarts at LOAD.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= IDLE;
            stepA <= '0;
        end else if (stopPulse) begin
            state <= IDLE;
            stepA <= '0;
        end else if (startPulse) begin
            state <= LOAD;
            stepA <= '0;
        end else begin
            case (state)
                LOAD: begin
                    state <= RUN;
                    stepA <= FirstStep;
                end
                RUN: begin
                    if (stepLast) begin
                        if (stepA == LastStep) begin
                            stepA <= FirstStep;
                        end else begin
                            stepA <= stepA + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ========================================
    // Round counter.
    // ========================================

    always_ff @(posedge clk) begin
        if (!rstN || startPulse || stopPulse) begin
            roundCount <= '0;
        end else if (roundDone) begin
            roundCount <= roundCount + 1'b1;
        end
    end

    stepInCycle: assert property (@(posedge clk) disable iff (!rstN)
        state == RUN |-> stepA inside {[FirstStep:LastStep]})
        else $error("stepA out of cycle in RUN: %h", stepA);

endmodule

`default_nettype wire

// ==== motor3StepTimer.sv ====
`default_nettype none

`include "motor3_config.svh"

module motor3StepTimer (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [`STEP_CNT_W-1:0] reloadValue,
    input  logic                   timerLoad,
    input  logic                   timerRun,
    output logic                   stepLast
);

    logic [`STEP_CNT_W-1:0] count;

    // Last cycle of a step is count 1.
    // Count 0 only shows up before the first load.
    assign stepLast = (count[`STEP_CNT_W-1:1] == '0);

    // ========================================
    // Down counter.
    // ========================================

    // The reload is sampled at every step boundary, so a new value
    // applies from the next step on.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= '0;
        end else if (timerLoad || stepLast) begin
            count <= reloadValue;
        end else if (timerRun) begin
            count <= count - 1'b1;
        end
    end

    // A running step always starts from a clamped, nonzero reload.
    countInRange: assert property (@(posedge clk) disable iff (!rstN)
        timerRun |-> (count != '0 && count <= `RELOAD_MAX))
        else $error("step count out of range: %h", count);

endmodule

`default_nettype wire

// ==== motor3Tb.sv ====
`default_nettype none

`include "motor3_config.svh"

module motor3Tb;
    timeunit 1ns;
    timeprecision 100ps;

    import motor3Pkg::*;

    localparam int ClkPeriod = 100;
    localparam int MinRandReload = 4;
    localparam int MaxReload = 40;
    // Step boundaries over all tests, partial steps included.
    localparam int PlannedSteps = 60;
    localparam int BusCycles = 400;
    localparam int WatchdogCycles = PlannedSteps * MaxReload + BusCycles;

    logic                   clk;
    logic                   rstN;
    logic                   wbCyc;
    logic                   wbStb;
    logic                   wbWe;
    logic [1:0]             wbAdr;
    logic [31:0]            wbDatW;
    logic [31:0]            wbDatR;
    logic                   wbAck;
    logic [`STEP_W-1:0]     stepA;
    logic [`STEP_W-1:0]     stepB;
    logic [`STEP_W-1:0]     stepC;
    logic [2:0]             phaseHigh;

    // Expected DUT state.
    logic                   modelAck;
    logic                   modelStart;
    logic                   modelStop;
    seqState_t              modelState;
    logic [`STEP_W-1:0]     modelStepA;
    logic [`ROUND_W-1:0]    modelRound;
    logic [`STEP_CNT_W-1:0] modelReload;
    logic [`STEP_CNT_W-1:0] modelRemain;
    logic [31:0]            modelDatR;
    logic                   request;
    logic                   writeCtrl;
    logic [31:0]            lfsr;
    logic [31:0]            reload;

    motor3Top motor3Top_i (
        .clk       (clk),
        .rstN      (rstN),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .wbDatR    (wbDatR),
        .wbAck     (wbAck),
        .stepA     (stepA),
        .stepB     (stepB),
        .stepC     (stepC),
        .phaseHigh (phaseHigh)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // Steps outside the cycle map to 15.
    function automatic logic [`STEP_W-1:0] wrapStep(input logic [`STEP_W-1:0] step,
                                                    input int offset);
        if (step < 1 || step > 12) begin
            return 4'd15;
        end
        return `STEP_W'((int'(step) - 1 + offset) % 12 + 1);
    endfunction

    function automatic logic driveHigh(input logic [`STEP_W-1:0] step);
        return step >= 1 && step <= 6;
    endfunction

    // Drive levels of C, B and A for a given phase A step.
    function automatic logic [2:0] expectedPhase(input logic [`STEP_W-1:0] step);
        return {driveHigh(wrapStep(step, 4)), driveHigh(wrapStep(step, 8)), driveHigh(step)};
    endfunction

    function automatic logic [`STEP_CNT_W-1:0] limitReload(input longint value);
        if (value < `RELOAD_MIN) begin
            return `RELOAD_MIN;
        end
        if (value > `RELOAD_MAX) begin
            return `RELOAD_MAX;
        end
        return value[`STEP_CNT_W-1:0];
    endfunction

    function automatic logic [31:0] lfsrNext(input logic [31:0] value);
        if (value[0]) begin
            return (value >> 1) ^ 32'h8020_0003;
        end
        return value >> 1;
    endfunction

    // ========================================
    // Reference model.
    // ========================================

    assign request   = wbCyc && wbStb && !modelAck;
    assign writeCtrl = request && wbWe && wbAdr == REG_CTRL;

    always @(posedge clk) begin
        if (!rstN) begin
            modelAck    <= 1'b0;
            modelStart  <= 1'b0;
            modelStop   <= 1'b0;
            modelReload <= `RELOAD_RESET;
            modelState  <= IDLE;
            modelStepA  <= '0;
            modelRound  <= '0;
            modelRemain <= '0;
        end else begin
            modelAck   <= request;
            modelStart <= writeCtrl && wbDatW[2:0] == CMD_START;
            modelStop  <= writeCtrl && wbDatW[2:0] == CMD_STOP;
            if (request && wbWe && wbAdr == REG_RELOAD) begin
                modelReload <= limitReload(longint'(wbDatW));
            end
            if (writeCtrl && wbDatW[2:0] == CMD_FASTER) begin
                modelReload <= limitReload(longint'(modelReload) - `RELOAD_DELTA);
            end
            if (writeCtrl && wbDatW[2:0] == CMD_SLOWER) begin
                modelReload <= limitReload(longint'(modelReload) + `RELOAD_DELTA);
            end
            if (request && !wbWe) begin
                case (wbAdr)
                    REG_CTRL:   modelDatR <= 32'(modelState);
                    REG_RELOAD: modelDatR <= 32'(modelReload);
                    REG_STEP:   modelDatR <= {20'd0, wrapStep(modelStepA, 4),
                                              wrapStep(modelStepA, 8), modelStepA};
                    default:    modelDatR <= modelRound;
                endcase
            end
            if (modelStop || modelStart) begin
                modelState <= modelStop ? IDLE : LOAD;
                modelStepA <= '0;
                modelRound <= '0;
            end else if (modelState == LOAD) begin
                modelState  <= RUN;
                modelStepA  <= 1;
                modelRemain <= modelReload;
            end else if (modelState == RUN) begin
                if (modelRemain <= 1) begin
                    modelRemain <= modelReload;
                    modelStepA  <= (modelStepA == 12) ? 4'd1 : modelStepA + 1'b1;
                    if (modelStepA == 12) begin
                        modelRound <= modelRound + 1'b1;
                    end
                end else begin
                    modelRemain <= modelRemain - 1'b1;
                end
            end
        end
    end

    // ========================================
    // Checks.
    // ========================================

    task automatic failRun();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        $display("ERR %s: got %h, expected %h", name, got, expected);
        failRun();
    endtask

    ackMatch: assert property (@(posedge clk) disable iff (!rstN) wbAck == modelAck)
        else reportMismatch("wbAck", $sampled(wbAck), $sampled(modelAck));
    stepAMatch: assert property (@(posedge clk) disable iff (!rstN) stepA == modelStepA)
        else reportMismatch("stepA", $sampled(stepA), $sampled(modelStepA));
    stepBMatch: assert property (@(posedge clk) disable iff (!rstN)
        stepB == wrapStep(modelStepA, 8))
        else reportMismatch("stepB", $sampled(stepB), wrapStep($sampled(modelStepA), 8));
    stepCMatch: assert property (@(posedge clk) disable iff (!rstN)
        stepC == wrapStep(modelStepA, 4))
        else reportMismatch("stepC", $sampled(stepC), wrapStep($sampled(modelStepA), 4));
    phaseMatch: assert property (@(posedge clk) disable iff (!rstN)
        phaseHigh == expectedPhase(modelStepA))
        else reportMismatch("phaseHigh", $sampled(phaseHigh),
                            expectedPhase($sampled(modelStepA)));

    // ========================================
    // Stimulus tasks.
    // ========================================

    task automatic takeBits(input int width, output int bits);
        bits = 0;
        repeat (width) begin
            bits = (bits << 1) | int'(lfsr[0]);
            lfsr = lfsrNext(lfsr);
        end
    endtask

    task automatic pickReload(output logic [31:0] value);
        int bits;
        takeBits(6, bits);
        value = MinRandReload + bits % (MaxReload - MinRandReload + 1);
    endtask

    // Starts and ends on a falling edge.
    task automatic busAccess(input logic we, input regAddr_t addr,
                             input logic [31:0] dataW, output logic [31:0] dataR);
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = we;
        wbAdr  = addr;
        wbDatW = dataW;
        @(posedge clk);
        @(negedge clk);
        assert (wbAck) else begin
            $display("No wbAck in the cycle after the request to %s.", addr.name());
            failRun();
        end
        assert (we || wbDatR == modelDatR) else reportMismatch("wbDatR", wbDatR, modelDatR);
        dataR = wbDatR;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
        @(negedge clk);
        assert (!wbAck) else begin
            $display("wbAck stayed high for a second cycle.");
            failRun();
        end
    endtask

    task automatic wbWrite(input regAddr_t addr, input logic [31:0] data);
        logic [31:0] unused;
        busAccess(1'b1, addr, data, unused);
    endtask

    task automatic wbRead(input regAddr_t addr, output logic [31:0] data);
        busAccess(1'b0, addr, 32'd0, data);
    endtask

    task automatic checkRead(input regAddr_t addr, input logic [31:0] expected);
        logic [31:0] data;
        wbRead(addr, data);
        assert (data == expected) else reportMismatch(addr.name(), data, expected);
    endtask

    task automatic waitSteps(input int count);
        logic [`STEP_W-1:0] last;
        repeat (count) begin
            last = modelStepA;
            while (modelStepA == last) begin
                @(negedge clk);
            end
        end
    endtask

    task automatic waitRounds(input int count);
        while (modelRound != count) begin
            @(negedge clk);
        end
    endtask

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("Timeout: the tests did not finish within %0d cycles.", WatchdogCycles);
        failRun();
    end

    initial begin
        clk    = 1'b0;
        rstN   = 1'b0;
        wbCyc  = 1'b0;
        wbStb  = 1'b0;
        wbWe   = 1'b0;
        wbAdr  = 2'd0;
        wbDatW = 32'd0;
        lfsr   = 32'h2e9f;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);

        checkRead(REG_RELOAD, `RELOAD_RESET);
        checkRead(REG_CTRL, IDLE);
        checkRead(REG_ROUND, 0);
        checkRead(REG_STEP, 32'h0000_0ff0);

        // Random period, two rounds, then stop.
        pickReload(reload);
        wbWrite(REG_RELOAD, reload);
        checkRead(REG_RELOAD, reload);
        wbWrite(REG_CTRL, CMD_START);
        waitRounds(2);
        checkRead(REG_ROUND, 2);
        checkRead(REG_CTRL, RUN);
        wbWrite(REG_CTRL, CMD_STOP);
        checkRead(REG_CTRL, IDLE);
        checkRead(REG_ROUND, 0);
        checkRead(REG_STEP, 32'h0000_0ff0);

        // Speed commands down to the lower limit.
        wbWrite(REG_RELOAD, 2);
        checkRead(REG_RELOAD, `RELOAD_MIN);
        wbWrite(REG_RELOAD, 9);
        wbWrite(REG_CTRL, CMD_START);
        waitSteps(2);
        wbWrite(REG_CTRL, CMD_FASTER);
        checkRead(REG_RELOAD, 7);
        waitSteps(2);
        wbWrite(REG_CTRL, CMD_FASTER);
        wbWrite(REG_CTRL, CMD_FASTER);
        checkRead(REG_RELOAD, `RELOAD_MIN);
        waitSteps(2);
        wbWrite(REG_CTRL, CMD_SLOWER);
        checkRead(REG_RELOAD, `RELOAD_MIN + `RELOAD_DELTA);
        waitSteps(3);
        wbWrite(REG_CTRL, CMD_STOP);

        // Restart in the middle of a run.
        pickReload(reload);
        wbWrite(REG_RELOAD, reload);
        wbWrite(REG_CTRL, CMD_START);
        waitRounds(1);
        checkRead(REG_ROUND, 1);
        wbWrite(REG_CTRL, CMD_START);
        checkRead(REG_ROUND, 0);
        waitSteps(3);
        wbWrite(REG_CTRL, CMD_STOP);
        checkRead(REG_CTRL, IDLE);

        @(negedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== motor3Top.sv ====
`default_nettype none

`include "motor3_config.svh"

module motor3Top (
    input  logic                clk,
    input  logic                rstN,
    input  logic                wbCyc,
    input  logic                wbStb,
    input  logic                wbWe,
    input  logic [1:0]          wbAdr,
    input  logic [31:0]         wbDatW,
    output logic [31:0]         wbDatR,
    output logic                wbAck,
    output logic [`STEP_W-1:0]  stepA,
    output logic [`STEP_W-1:0]  stepB,
    output logic [`STEP_W-1:0]  stepC,
    output logic [2:0]          phaseHigh
);
    import motor3Pkg::*;

    seqState_t              state;
    logic [`STEP_CNT_W-1:0] reloadValue;
    logic [`ROUND_W-1:0]    roundCount;
    logic                   startPulse;
    logic                   stopPulse;
    logic                   timerLoad;
    logic                   timerRun;
    logic                   stepLast;

    motor3WbRegs motor3WbRegs_i (
        .clk         (clk),
        .rstN        (rstN),
        .wbCyc       (wbCyc),
        .wbStb       (wbStb),
        .wbWe        (wbWe),
        .wbAdr       (wbAdr),
        .wbDatW      (wbDatW),
        .wbDatR      (wbDatR),
        .wbAck       (wbAck),
        .state       (state),
        .stepA       (stepA),
        .stepB       (stepB),
        .stepC       (stepC),
        .roundCount  (roundCount),
        .reloadValue (reloadValue),
        .startPulse  (startPulse),
        .stopPulse   (stopPulse)
    );

    motor3StepTimer motor3StepTimer_i (
        .clk         (clk),
        .rstN        (rstN),
        .reloadValue (reloadValue),
        .timerLoad   (timerLoad),
        .timerRun    (timerRun),
        .stepLast    (stepLast)
    );

    motor3Sequencer motor3Sequencer_i (
        .clk        (clk),
        .rstN       (rstN),
        .startPulse (startPulse),
        .stopPulse  (stopPulse),
        .stepLast   (stepLast),
        .state      (state),
        .timerLoad  (timerLoad),
        .timerRun   (timerRun),
        .stepA      (stepA),
        .roundCount (roundCount)
    );

    motor3PhaseMap motor3PhaseMap_i (
        .stepA     (stepA),
        .stepB     (stepB),
        .stepC     (stepC),
        .phaseHigh (phaseHigh)
    );

endmodule

`default_nettype wire

// ==== motor3WbRegs.sv ====
`default_nettype none

`include "motor3_config.svh"

module motor3WbRegs (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   wbCyc,
    input  logic                   wbStb,
    input  logic                   wbWe,
    input  logic [1:0]             wbAdr,
    input  logic [31:0]            wbDatW,
    output logic [31:0]            wbDatR,
    output logic                   wbAck,
    input  motor3Pkg::seqState_t   state,
    input  logic [`STEP_W-1:0]     stepA,
    input  logic [`STEP_W-1:0]     stepB,
    input  logic [`STEP_W-1:0]     stepC,
    input  logic [`ROUND_W-1:0]    roundCount,
    output logic [`STEP_CNT_W-1:0] reloadValue,
    output logic                   startPulse,
    output logic                   stopPulse
);
    import motor3Pkg::*;

    logic      request;
    regAddr_t  adr;
    motorCmd_t cmd;

    // A new access is taken only while no ack is out.
    assign request = wbCyc && wbStb && !wbAck;
    assign adr     = regAddr_t'(wbAdr);
    assign cmd     = motorCmd_t'(wbDatW[2:0]);

    // Written reload limited to the legal range.
    function automatic logic [`STEP_CNT_W-1:0] clampReload(input logic [31:0] value);
        logic [`STEP_CNT_W-1:0] result;
        if (value < `RELOAD_MIN) begin
            result = `RELOAD_MIN;
        end else if (value > `RELOAD_MAX) begin
            result = `RELOAD_MAX;
        end else begin
            result = value[`STEP_CNT_W-1:0];
        end
        return result;
    endfunction

    function automatic logic [`STEP_CNT_W-1:0] fasterReload(
        input logic [`STEP_CNT_W-1:0] value
    );
        if (value < `RELOAD_MIN + `RELOAD_DELTA) begin
            return `RELOAD_MIN;
        end
        return value - `RELOAD_DELTA;
    endfunction

    function automatic logic [`STEP_CNT_W-1:0] slowerReload(
        input logic [`STEP_CNT_W-1:0] value
    );
        if (value > `RELOAD_MAX - `RELOAD_DELTA) begin
            return `RELOAD_MAX;
        end
        return value + `RELOAD_DELTA;
    endfunction

    // ========================================
    // Ack, commands and reload register.
    // ========================================

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbAck       <= 1'b0;
            startPulse  <= 1'b0;
            stopPulse   <= 1'b0;
            reloadValue <= `RELOAD_RESET;
        end else begin
            wbAck      <= request;
            startPulse <= 1'b0;
            stopPulse  <= 1'b0;
            if (request && wbWe) begin
                case (adr)
                    REG_CTRL: begin
                        case (cmd)
                            CMD_START:  startPulse  <= 1'b1;
                            CMD_STOP:   stopPulse   <= 1'b1;
                            CMD_FASTER: reloadValue <= fasterReload(reloadValue);
                            CMD_SLOWER: reloadValue <= slowerReload(reloadValue);
                            default: ;
                        endcase
                    end
                    REG_RELOAD: reloadValue <= clampReload(wbDatW);
                    default: ;
                endcase
            end
        end
    end

    // Read data lines up with the ack.
    always_ff @(posedge clk) begin
        if (request && !wbWe) begin
            case (adr)
                REG_CTRL:   wbDatR <= {30'd0, state};
                REG_RELOAD: wbDatR <= {{(32 - `STEP_CNT_W){1'b0}}, reloadValue};
                REG_STEP:   wbDatR <= {{(32 - 3 * `STEP_W){1'b0}}, stepC, stepB, stepA};
                default:    wbDatR <= roundCount;
            endcase
        end
    end

    ackSinglePulse: assert property (@(posedge clk) disable iff (!rstN)
        wbAck |=> !wbAck)
        else $error("wbAck held for two cycles");

endmodule

`default_nettype wire

// ==== motor3_config.svh ====
`ifndef MOTOR3_CONFIG_SVH
`define MOTOR3_CONFIG_SVH

// ========================================
// Widths.
// ========================================

// Reload value and step timer count.
`define STEP_CNT_W 25
`define ROUND_W 32
`define STEP_W 4

// ========================================
// Reload limits.
// ========================================

`define RELOAD_RESET 25'd1000
`define RELOAD_MIN 25'd4
// 2^25 - 1, the largest count the timer holds.
`define RELOAD_MAX 25'd33554431
// Step of one faster or slower command.
`define RELOAD_DELTA 25'd2

`endif
